//--- mouseHost.f
rtl/ps2ProtocolPkg.sv
rtl/mouseDataPkg.sv
rtl/mouseInitSequencer.sv
rtl/mousePacketAssembler.sv
rtl/mouseHost.sv
verif/mouseHost_properties.sv
verif/mouseHostTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mouseHostTb
FILELIST  ?= mouseHost.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/mouseHostTb.sv
module mouseHostTb;

    localparam int powerUpCycles = 20;
    localparam int runCount      = 5;
    localparam int packetsPerRun = 8;
    // Setup and streaming budget with a factor of two for margin
    localparam int cycleLimit = 2 * (runCount * (powerUpCycles + 12 * 20) +
                                     runCount * packetsPerRun * 4 * 12);

    // Fault injected in a run
    localparam int kindClean       = 0;
    localparam int kindWrongReply  = 1;
    localparam int kindSetupError  = 2;
    localparam int kindStreamError = 3;

    logic                        CLK;
    logic                        RESET;
    logic                        byteSent;
    mouseDataPkg::rxByte         rx;
    mouseDataPkg::txRequest      tx;
    logic                        readEnable;
    mouseDataPkg::movementPacket packet;
    logic                        packetStrobe;
    logic                        linkUp;
    logic                        wheelPresent;

    integer seed;
    int     errorCount;
    int     checkCount;
    int     cycleCount = 0;
    // Cycle where the current power-up wait began
    int     idleSince;
    bit     sendExpected;
    // Last byte of a packet goes out in the current cycle
    bit     strobeDue;
    // Model answered get device ID with the wheel ID
    bit     modelWheel;
    bit     setupOk;
    // Packets sent by the mouse model in sending order
    mouseDataPkg::movementPacket expected[$];

    mouseHost #(
        .powerUpCycles (powerUpCycles)
    ) UUT (
        .CLK          (CLK),
        .RESET        (RESET),
        .byteSent     (byteSent),
        .rx           (rx),
        .tx           (tx),
        .readEnable   (readEnable),
        .packet       (packet),
        .packetStrobe (packetStrobe),
        .linkUp       (linkUp),
        .wheelPresent (wheelPresent)
    );

    always #20 CLK = ~CLK;

    // Hard stop for a stuck handshake
    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: test still running after %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Random helpers and the mouse's own script
    //////////////////////////////////////////////////

    function automatic int randomRange(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic ps2ProtocolPkg::ps2Byte randomByte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Command order a wheel-capable mouse expects
    function automatic ps2ProtocolPkg::ps2Byte scriptByte(input int step);
        ps2ProtocolPkg::ps2Byte script [9];
        script = '{8'hFF, 8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50, 8'hF2, 8'hF4};
        return script[step];
    endfunction

    // Reset gets three replies and get ID gets two
    function automatic int replyCount(input int step);
        return (step == 0) ? 3 : ((step == 7) ? 2 : 1);
    endfunction

    function automatic ps2ProtocolPkg::ps2Byte replyByte(input int step, input int index,
                                                          input ps2ProtocolPkg::ps2Byte id);
        if (index == 0) return 8'hFA;
        if (step == 0) return (index == 1) ? 8'hAA : 8'h00;
        return id;
    endfunction

    // Wire order is status, dx, dy, dz
    function automatic ps2ProtocolPkg::ps2Byte packetByte(input mouseDataPkg::movementPacket pkt,
                                                           input int index);
        case (index)
            0:       return pkt.status;
            1:       return pkt.dx;
            2:       return pkt.dy;
            default: return pkt.dz;
        endcase
    endfunction

    // Fault schedule with a clean last run
    function automatic int runKind(input int run);
        case (run)
            0:       return kindWrongReply;
            1:       return kindStreamError;
            2:       return kindSetupError;
            3:       return kindStreamError;
            default: return kindClean;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Checks and cycle stepping
    //////////////////////////////////////////////////

    task automatic check(input bit cond, input string msg);
        checkCount++;
        assert (cond) else begin
            errorCount++;
            $display("CHECK FAILED at time %0t: %s", $time, msg);
        end
    endtask

    // Next falling edge plus the per-cycle rules
    task automatic tick();
        mouseDataPkg::movementPacket want;
        @(negedge CLK);
        if (!sendExpected) begin
            check(!tx.send, "tx.send before the previous reply finished");
        end
        check(!(tx.send && readEnable), "tx.send while readEnable is high");
        check(!packetStrobe || linkUp, "packetStrobe while linkUp is low");
        if (strobeDue) begin
            check(packetStrobe, "no packetStrobe in the cycle after a packet's last byte");
        end else begin
            check(!packetStrobe, "packetStrobe with no packet just finished");
        end
        strobeDue = 1'b0;
        if (packetStrobe) begin
            if (expected.size() == 0) begin
                check(1'b0, "packetStrobe with no packet sent");
            end else begin
                want = expected.pop_front();
                check(packet == want, $sformatf("packet %h, expected %h", packet, want));
            end
        end
    endtask

    task automatic waitCycles(input int count);
        repeat (count) tick();
    endtask

    // One receiver strobe driven just after a falling edge
    task automatic sendByte(input ps2ProtocolPkg::ps2Byte data,
                            input ps2ProtocolPkg::rxErrorCode code);
        rx = {1'b1, code, data};
        tick();
        rx.ready = 1'b0;
    endtask

    task automatic waitForSend();
        sendExpected = 1'b1;
        do begin
            tick();
        end while (!tx.send);
        sendExpected = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Mouse model
    //////////////////////////////////////////////////

    task automatic serveStep(input int step, input ps2ProtocolPkg::ps2Byte id, input int kind,
                             input int faultStep, input int faultIndex, output bit ok);
        ps2ProtocolPkg::ps2Byte reply;
        waitForSend();
        check(tx.data == scriptByte(step), $sformatf("command %h at step %0d, expected %h",
                                                     tx.data, step, scriptByte(step)));
        check(!linkUp, "linkUp high during setup");
        if (step == 0) begin
            check(cycleCount - idleSince >= powerUpCycles, "reset command before power-up wait");
        end
        // Transmitter shifting the byte out
        waitCycles(randomRange(1, 8));
        byteSent = 1'b1;
        tick();
        byteSent = 1'b0;
        ok = 1'b1;
        for (int i = 0; i < replyCount(step) && ok; i++) begin
            while (!readEnable) tick();
            waitCycles(randomRange(0, 3));
            reply = replyByte(step, i, id);
            if (step == faultStep && i == faultIndex) begin
                ok = 1'b0;
                if (kind == kindWrongReply) begin
                    // Flipping bit 4 misses every valid reply and ID
                    sendByte(reply ^ (8'h10 | randomByte()), 2'b00);
                end else begin
                    sendByte(reply, ps2ProtocolPkg::rxErrorCode'(randomRange(1, 3)));
                end
                check(!readEnable && !linkUp, "setup went on after a bad reply");
                idleSince = cycleCount;
            end else begin
                sendByte(reply, 2'b00);
            end
        end
    endtask

    task automatic runSetup(input int kind, output bit ok);
        ps2ProtocolPkg::ps2Byte id;
        int                     faultStep;
        int                     faultIndex;
        modelWheel = (randomRange(0, 1) == 1);
        id         = modelWheel ? 8'h03 : 8'h00;
        faultStep  = -1;
        faultIndex = 0;
        if (kind == kindWrongReply || kind == kindSetupError) begin
            faultStep  = randomRange(0, 8);
            faultIndex = randomRange(0, replyCount(faultStep) - 1);
        end
        ok = 1'b1;
        for (int step = 0; step < 9 && ok; step++) begin
            serveStep(step, id, kind, faultStep, faultIndex, ok);
        end
        if (ok) begin
            check(linkUp, "linkUp low after the enable acknowledge");
            check(wheelPresent == modelWheel, $sformatf("wheelPresent %b for ID %h",
                                                        wheelPresent, id));
        end
    endtask

    task automatic streamPackets(input int count);
        mouseDataPkg::movementPacket pkt;
        int                          lastIndex;
        lastIndex = modelWheel ? 3 : 2;
        for (int p = 0; p < count; p++) begin
            pkt.status = randomByte();
            pkt.dx     = randomByte();
            pkt.dy     = randomByte();
            pkt.dz     = modelWheel ? randomByte() : 8'h00;
            waitCycles(randomRange(0, 5));
            for (int b = 0; b <= lastIndex; b++) begin
                while (!readEnable) tick();
                // Queued before its last byte goes out
                if (b == lastIndex) begin
                    expected.push_back(pkt);
                    strobeDue = 1'b1;
                end
                sendByte(packetByte(pkt, b), 2'b00);
                waitCycles(randomRange(0, 3));
            end
        end
    endtask

    // Partial packet ending in a receive error
    task automatic breakStream();
        repeat (randomRange(0, modelWheel ? 3 : 2)) begin
            sendByte(randomByte(), 2'b00);
            waitCycles(randomRange(0, 3));
        end
        sendByte(randomByte(), ps2ProtocolPkg::rxErrorCode'(randomRange(1, 3)));
        check(!linkUp && !readEnable, "link still up after a receive error");
        check(expected.size() == 0, "packets missing before the receive error");
        idleSince = cycleCount;
    endtask

    initial begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        byteSent     = 1'b0;
        rx           = '0;
        seed         = 32'hd58d_1f91;
        errorCount   = 0;
        checkCount   = 0;
        sendExpected = 1'b0;
        strobeDue    = 1'b0;
        modelWheel   = 1'b0;
        idleSince    = 0;
        // Outputs quiet through reset and just after
        repeat (2) begin
            tick();
            check({tx.send, readEnable, packetStrobe, linkUp, wheelPresent} == 5'b0,
                  "output high during reset");
        end
        RESET     = 1'b0;
        idleSince = cycleCount;
        repeat (3) begin
            tick();
            check({tx.send, readEnable, packetStrobe, linkUp, wheelPresent} == 5'b0,
                  "output high right after reset");
        end
        for (int run = 0; run < runCount; run++) begin
            runSetup(runKind(run), setupOk);
            if (setupOk) begin
                streamPackets(packetsPerRun);
                if (runKind(run) == kindStreamError) breakStream();
            end
        end
        waitCycles(4);
        check(expected.size() == 0, $sformatf("%0d packets never reported", expected.size()));
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verif/mouseHost_properties.sv
module mouseHost_properties (
    input logic                   CLK,
    input logic                   RESET,
    input mouseDataPkg::txRequest tx,
    input logic                   readEnable,
    input logic                   packetStrobe,
    input logic                   linkUp
);

    //////////////////////////////////////////////////
    // Top-level handshake rules
    //////////////////////////////////////////////////

    // Packet strobe is a single cycle pulse
    strobeSingle: assert property (@(posedge CLK) disable iff (RESET)
        packetStrobe |=> !packetStrobe)
        else $error("packetStrobe high for two cycles");

    // Packets only once the link is up
    strobeLinked: assert property (@(posedge CLK) disable iff (RESET)
        packetStrobe |-> linkUp)
        else $error("packetStrobe while linkUp is low");

    // No commands while streaming
    sendSetupOnly: assert property (@(posedge CLK) disable iff (RESET)
        tx.send |-> !linkUp)
        else $error("tx.send while linkUp is high");

    // Transmit and listen never overlap
    sendNotReading: assert property (@(posedge CLK) disable iff (RESET)
        !(tx.send && readEnable))
        else $error("tx.send and readEnable high together");

endmodule

bind mouseHost mouseHost_properties hostProperties (
    .CLK          (CLK),
    .RESET        (RESET),
    .tx           (tx),
    .readEnable   (readEnable),
    .packetStrobe (packetStrobe),
    .linkUp       (linkUp)
);

//--- rtl/mouseHost.sv
module mouseHost #(
    parameter int unsigned powerUpCycles = 1000000
) (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        byteSent,
    input  mouseDataPkg::rxByte         rx,
    output mouseDataPkg::txRequest      tx,
    output logic                        readEnable,
    output mouseDataPkg::movementPacket packet,
    output logic                        packetStrobe,
    output logic                        linkUp,
    output logic                        wheelPresent
);

    // Read enable shares
    logic seqReadEnable;
    logic asmReadEnable;
    // Streaming error back to the setup side
    logic restart;

    //////////////////////////////////////////////////
    // Setup phase
    //////////////////////////////////////////////////

    mouseInitSequencer #(
        .powerUpCycles (powerUpCycles)
    ) initSequencer (
        .CLK          (CLK),
        .RESET        (RESET),
        .byteSent     (byteSent),
        .rx           (rx),
        .restart      (restart),
        .tx           (tx),
        .readEnable   (seqReadEnable),
        .linkUp       (linkUp),
        .wheelPresent (wheelPresent)
    );

    //////////////////////////////////////////////////
    // Streaming phase
    //////////////////////////////////////////////////

    mousePacketAssembler packetAssembler (
        .CLK          (CLK),
        .RESET        (RESET),
        .linkUp       (linkUp),
        .wheelPresent (wheelPresent),
        .rx           (rx),
        .readEnable   (asmReadEnable),
        .restart      (restart),
        .packet       (packet),
        .packetStrobe (packetStrobe)
    );

    // Phases never overlap, so a plain OR is enough
    assign readEnable = seqReadEnable | asmReadEnable;

endmodule

//--- rtl/mousePacketAssembler.sv
module mousePacketAssembler (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        linkUp,
    input  logic                        wheelPresent,
    input  mouseDataPkg::rxByte         rx,
    output logic                        readEnable,
    output logic                        restart,
    output mouseDataPkg::movementPacket packet,
    output logic                        packetStrobe
);

    // Position of the next byte within the packet
    typedef enum logic [1:0] {
        byteStatus,
        byteDx,
        byteDy,
        byteDz
    } bytePosition;

    bytePosition                 position;
    mouseDataPkg::movementPacket shadow;
    mouseDataPkg::movementPacket completed;
    logic                        byteClean;
    logic                        byteError;
    logic                        lastByte;

    // Always listening once the link is up
    assign readEnable = linkUp;

    assign byteClean = linkUp && rx.ready &&
                       (rx.errorCode == ps2ProtocolPkg::rxErrorCode'(0));
    assign byteError = linkUp && rx.ready &&
                       (rx.errorCode != ps2ProtocolPkg::rxErrorCode'(0));

    // Sequencer drops linkUp on this strobe
    assign restart = byteError;

    // Plain mouse ends on dy, wheel mouse on dz
    assign lastByte = (position == byteDz) || ((position == byteDy) && !wheelPresent);

    //////////////////////////////////////////////////
    // Byte position tracking
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET || !linkUp || byteError) begin
            position <= byteStatus;
        end else if (byteClean) begin
            position <= lastByte ? byteStatus : bytePosition'(position + 2'd1);
        end
    end

    //////////////////////////////////////////////////
    // Packet capture
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (byteClean) begin
            case (position)
                byteStatus: shadow.status <= rx.data;
                byteDx:     shadow.dx     <= rx.data;
                byteDy:     shadow.dy     <= rx.data;
                default:    shadow.dz     <= rx.data;
            endcase
        end
    end

    // Shadow plus the byte arriving now
    always_comb begin
        completed = shadow;
        if (position == byteDy) begin
            completed.dy = rx.data;
            completed.dz = ps2ProtocolPkg::ps2Byte'(0);
        end else begin
            completed.dz = rx.data;
        end
    end

    // Output updates one cycle after the last byte
    always_ff @(posedge CLK) begin
        if (byteClean && lastByte) begin
            packet <= completed;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            packetStrobe <= 1'b0;
        end else begin
            packetStrobe <= byteClean && lastByte;
        end
    end

endmodule

//--- rtl/mouseInitSequencer.sv
module mouseInitSequencer #(
    parameter int unsigned powerUpCycles = 1000000
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   byteSent,
    input  mouseDataPkg::rxByte    rx,
    input  logic                   restart,
    output mouseDataPkg::txRequest tx,
    output logic                   readEnable,
    output logic                   linkUp,
    output logic                   wheelPresent
);

    localparam int countWidth = $clog2(powerUpCycles + 1);
    // Script positions with more than one reply
    localparam logic [3:0] resetStep = 4'd0;
    localparam logic [3:0] idStep    = 4'd7;
    localparam logic [3:0] lastStep  = 4'd8;

    typedef enum logic [2:0] {
        waitPowerUp,
        sendCommand,
        waitSent,
        waitReply,
        linked
    } seqState;

    seqState               state;
    logic [countWidth-1:0] waitCount;
    // Index into the command script
    logic [3:0]            step;
    // Reply number within the current step
    logic [1:0]            replyIndex;
    logic                  sendPulse;
    logic                  idReply;
    logic                  replyLast;
    logic                  dataOk;
    logic                  replyOk;
    logic                  abort;

    // Setup script, one byte per step
    function automatic ps2ProtocolPkg::ps2Byte scriptCommand(input logic [3:0] index);
        case (index)
            4'd0:    scriptCommand = ps2ProtocolPkg::CMD_RESET;
            4'd2:    scriptCommand = ps2ProtocolPkg::WHEEL_RATE_FIRST;
            4'd4:    scriptCommand = ps2ProtocolPkg::WHEEL_RATE_SECOND;
            4'd6:    scriptCommand = ps2ProtocolPkg::WHEEL_RATE_THIRD;
            4'd7:    scriptCommand = ps2ProtocolPkg::CMD_GET_DEVICE_ID;
            4'd8:    scriptCommand = ps2ProtocolPkg::CMD_ENABLE_REPORTING;
            // Steps 1, 3 and 5 open a rate setting
            default: scriptCommand = ps2ProtocolPkg::CMD_SET_SAMPLE_RATE;
        endcase
    endfunction

    // Second reply of get device ID carries the ID
    assign idReply = (step == idStep) && (replyIndex == 2'd1);

    // Reset gets ACK, self-test and ID, get ID gets two, rest one
    always_comb begin
        replyLast = 1'b1;
        if (step == resetStep) begin
            replyLast = (replyIndex == 2'd2);
        end else if (step == idStep) begin
            replyLast = (replyIndex == 2'd1);
        end
    end

    // Reply check, any error code fails
    always_comb begin
        if (idReply) begin
            dataOk = (rx.data == ps2ProtocolPkg::ID_WHEEL) ||
                     (rx.data == ps2ProtocolPkg::ID_STANDARD);
        end else if (replyIndex == 2'd0) begin
            dataOk = (rx.data == ps2ProtocolPkg::REPLY_ACK);
        end else if (replyIndex == 2'd1) begin
            dataOk = (rx.data == ps2ProtocolPkg::REPLY_SELF_TEST_PASS);
        end else begin
            dataOk = (rx.data == ps2ProtocolPkg::ID_STANDARD);
        end
        replyOk = dataOk && (rx.errorCode == ps2ProtocolPkg::rxErrorCode'(0));
    end

    // Bad reply or streaming error restarts the whole script
    assign abort = restart || ((state == waitReply) && rx.ready && !replyOk);

    always_ff @(posedge CLK) begin
        if (RESET || abort) begin
            state        <= waitPowerUp;
            waitCount    <= '0;
            step         <= resetStep;
            replyIndex   <= '0;
            sendPulse    <= 1'b0;
            linkUp       <= 1'b0;
            wheelPresent <= 1'b0;
        end else begin
            sendPulse <= 1'b0;
            case (state)
                // Give the mouse time to power up
                waitPowerUp: begin
                    if (waitCount == countWidth'(powerUpCycles - 1)) begin
                        state     <= sendCommand;
                        waitCount <= '0;
                    end else begin
                        waitCount <= waitCount + 1'b1;
                    end
                end
                sendCommand: begin
                    sendPulse <= 1'b1;
                    state     <= waitSent;
                end
                waitSent: begin
                    if (byteSent) begin
                        state <= waitReply;
                    end
                end
                // Only clean, expected replies get here
                waitReply: begin
                    if (rx.ready) begin
                        if (idReply) begin
                            wheelPresent <= (rx.data == ps2ProtocolPkg::ID_WHEEL);
                        end
                        if (!replyLast) begin
                            replyIndex <= replyIndex + 1'b1;
                        end else if (step == lastStep) begin
                            state  <= linked;
                            linkUp <= 1'b1;
                        end else begin
                            step       <= step + 1'b1;
                            replyIndex <= '0;
                            state      <= sendCommand;
                        end
                    end
                end
                // Streaming, left only through restart
                linked: state <= linked;
                default: state <= waitPowerUp;
            endcase
        end
    end

    assign tx.send    = sendPulse;
    assign tx.data    = scriptCommand(step);
    assign readEnable = (state == waitReply);

endmodule

//--- rtl/mouseDataPkg.sv
package mouseDataPkg;

    //////////////////////////////////////////////////
    // Link level bundles
    //////////////////////////////////////////////////

    // Byte handed over by the receiver
    typedef struct packed {
        // Single cycle strobe
        logic                       ready;
        ps2ProtocolPkg::rxErrorCode errorCode;
        ps2ProtocolPkg::ps2Byte     data;
    } rxByte;

    // Byte handed to the transmitter
    typedef struct packed {
        // Single cycle strobe, no back-pressure
        logic                   send;
        ps2ProtocolPkg::ps2Byte data;
    } txRequest;

    //////////////////////////////////////////////////
    // Movement data
    //////////////////////////////////////////////////

    // Fields in wire order
    typedef struct packed {
        ps2ProtocolPkg::ps2Byte status;
        ps2ProtocolPkg::ps2Byte dx;
        ps2ProtocolPkg::ps2Byte dy;
        // Zero for a plain mouse
        ps2ProtocolPkg::ps2Byte dz;
    } movementPacket;

endpackage

//--- rtl/ps2ProtocolPkg.sv
package ps2ProtocolPkg;

    //////////////////////////////////////////////////
    // Basic protocol types
    //////////////////////////////////////////////////

    // One byte on the PS/2 wire
    typedef logic [7:0] ps2Byte;

    // Receiver error code, zero for a clean byte
    typedef logic [1:0] rxErrorCode;

    //////////////////////////////////////////////////
    // Host to mouse commands
    //////////////////////////////////////////////////

    // Full mouse reset, answered by ACK, self-test pass and ID
    localparam ps2Byte CMD_RESET            = 8'hFF;
    // Next byte sent is the sample rate
    localparam ps2Byte CMD_SET_SAMPLE_RATE  = 8'hF3;
    // Answered by ACK and then the device ID
    localparam ps2Byte CMD_GET_DEVICE_ID    = 8'hF2;
    // Mouse starts streaming movement packets
    localparam ps2Byte CMD_ENABLE_REPORTING = 8'hF4;

    // Magic rate sequence 200, 100, 80
    // Unlocks the scroll wheel on wheel mice
    localparam ps2Byte WHEEL_RATE_FIRST     = 8'hC8;
    localparam ps2Byte WHEEL_RATE_SECOND    = 8'h64;
    localparam ps2Byte WHEEL_RATE_THIRD     = 8'h50;

    //////////////////////////////////////////////////
    // Mouse to host replies
    //////////////////////////////////////////////////

    // Command acknowledge
    localparam ps2Byte REPLY_ACK            = 8'hFA;
    // Sent after the reset self-test
    localparam ps2Byte REPLY_SELF_TEST_PASS = 8'hAA;

    // Device IDs
    // Plain mouse sends 3 byte packets
    localparam ps2Byte ID_STANDARD          = 8'h00;
    // Wheel mouse adds a dz byte
    localparam ps2Byte ID_WHEEL             = 8'h03;

endpackage
